// ==== dv/tb_hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hazard_consts.svh"

module tb_hazard_unit;

    localparam int K_NONE  = 0;  // nop and j
    localparam int K_CALR  = 1;
    localparam int K_CALI  = 2;
    localparam int K_LOAD  = 3;
    localparam int K_STORE = 4;
    localparam int K_BR    = 5;
    localparam int K_JR    = 6;
    localparam int K_JALR  = 7;
    localparam int K_JAL   = 8;
    localparam int TOTAL_VECS = 4 + 4 + 200 + 200 + 300 + 200 + 2000;

    localparam logic [47:0] ALU_FN = {`HZ_FN_ADD, `HZ_FN_ADDU, `HZ_FN_SUBU, `HZ_FN_AND,
                                      `HZ_FN_NOR, `HZ_FN_SLT, `HZ_FN_SLLV, `HZ_FN_SRA};
    localparam logic [23:0] IMM_OP = {`HZ_OP_ADDIU, `HZ_OP_SLTI, `HZ_OP_ORI, `HZ_OP_LUI};
    localparam logic [23:0] LD_OP  = {`HZ_OP_LB, `HZ_OP_LHU, `HZ_OP_LBU, `HZ_OP_LW};
    localparam logic [23:0] ST_OP  = {`HZ_OP_SB, `HZ_OP_SH, `HZ_OP_SW, `HZ_OP_SW};
    localparam logic [23:0] BR_OP  = {`HZ_OP_BEQ, `HZ_OP_BNE, `HZ_OP_BLEZ, `HZ_OP_BGTZ};

    logic        clk;
    logic        rst;  // Holds nop words on all stages
    logic [31:0] ir_d;
    logic [31:0] ir_e;
    logic [31:0] ir_m;
    logic [31:0] ir_w;
    logic [1:0]  fwd_rs_d;
    logic [1:0]  fwd_rt_d;
    logic [1:0]  fwd_rs_e;
    logic [1:0]  fwd_rt_e;
    logic [1:0]  fwd_rt_m;
    logic        enable;
    logic        clear;
    integer      seed;
    int          errors;
    int          checks;

    always #10 clk = ~clk;

    hazard_unit i_dut (
        .ir_d (ir_d), .ir_e (ir_e), .ir_m (ir_m), .ir_w (ir_w),
        .fwd_rs_d (fwd_rs_d), .fwd_rt_d (fwd_rt_d), .fwd_rs_e (fwd_rs_e),
        .fwd_rt_e (fwd_rt_e), .fwd_rt_m (fwd_rt_m), .enable (enable), .clear (clear)
    );

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] rand_reg();
        int r;
        r = rand_below(5);
        return (r == 4) ? 5'd31 : 5'(r);  // r0..r3 and r31 only
    endfunction

    function automatic int pick4(input int a, input int b, input int c, input int d);
        int r;
        r = rand_below(4);
        return (r == 0) ? a : (r == 1) ? b : (r == 2) ? c : d;
    endfunction

    function automatic int rand_kind();
        int k;
        case (rand_below(16))
            0, 1, 2, 3: k = K_CALR;
            4, 5, 6:    k = K_CALI;
            7, 8, 9:    k = K_LOAD;
            10, 11:     k = K_STORE;
            12:         k = K_BR;
            13:         k = K_JR;
            14:         k = K_JALR;
            default:    k = (rand_below(2) == 0) ? K_JAL : K_NONE;
        endcase
        return k;
    endfunction

    function automatic logic [31:0] make_word(input int kind);
        int          sel;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] w;
        sel = rand_below(16);
        rs  = rand_reg();
        rt  = rand_reg();
        rd  = rand_reg();
        imm = $random(seed);
        case (kind)
            K_CALR:  w = {`HZ_OP_SPECIAL, rs, rt, rd, 5'd2, ALU_FN[6*(sel%8) +: 6]};
            K_CALI:  w = {IMM_OP[6*(sel%4) +: 6], rs, rt, imm};
            K_LOAD:  w = {LD_OP[6*(sel%4) +: 6], rs, rt, imm};
            K_STORE: w = {ST_OP[6*(sel%4) +: 6], rs, rt, imm};
            K_BR:    w = (sel >= 12) ? {`HZ_OP_REGIMM, rs, 4'b0000, sel[0], imm}
                                     : {BR_OP[6*(sel%4) +: 6], rs, rt, imm};
            K_JR:    w = {`HZ_OP_SPECIAL, rs, 15'd0, `HZ_FN_JR};
            K_JALR:  w = {`HZ_OP_SPECIAL, rs, 5'd0, rd, 5'd0, `HZ_FN_JALR};
            K_JAL:   w = {`HZ_OP_JAL, rs, rt, imm};
            default: w = sel[0] ? 32'h0 : {`HZ_OP_J, rs, rt, imm};
        endcase
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic int kind_of(input logic [31:0] w);
        logic [5:0] op;
        logic [5:0] fn;
        int         k;
        op = w[31:26];
        fn = w[5:0];
        k  = K_NONE;
        if (op == `HZ_OP_SPECIAL) begin
            if (fn == `HZ_FN_JR) begin
                k = K_JR;
            end else if (fn == `HZ_FN_JALR) begin
                k = K_JALR;
            end else if (fn[5:3] == 3'b100 || fn[5:1] == 5'b10101 ||
                         (fn[5:3] == 3'b000 && fn[1:0] != 2'b01)) begin
                k = K_CALR;  // Arithmetic, slt/sltu and the six shifts
            end
        end else if (op == `HZ_OP_REGIMM) begin
            k = (w[20:17] == 4'b0000) ? K_BR : K_NONE;
        end else if (op == `HZ_OP_JAL) begin
            k = K_JAL;
        end else if (op[5:2] == 4'b0001) begin
            k = K_BR;
        end else if (op[5:3] == 3'b001) begin
            k = K_CALI;
        end else if (op == `HZ_OP_LB || op == `HZ_OP_LH || op == `HZ_OP_LW ||
                     op == `HZ_OP_LBU || op == `HZ_OP_LHU) begin
            k = K_LOAD;
        end else if (op == `HZ_OP_SB || op == `HZ_OP_SH || op == `HZ_OP_SW) begin
            k = K_STORE;
        end
        return k;
    endfunction

    function automatic logic [4:0] dest_of(input logic [31:0] w);
        int k;
        k = kind_of(w);
        if (k == K_CALR || k == K_JALR) return w[15:11];
        if (k == K_CALI || k == K_LOAD) return w[20:16];
        if (k == K_JAL) return 5'd31;
        return 5'd0;
    endfunction

    function automatic logic hit(input logic [4:0] dst, input logic [4:0] src);
        return dst != 5'd0 && dst == src;
    endfunction

    function automatic logic [1:0] fwd_model(input logic reads, input logic [4:0] src,
                                             input int km, input logic [4:0] dm,
                                             input logic [4:0] dw);
        if (!reads || src == 5'd0) return 2'd0;
        if ((km == K_CALR || km == K_CALI) && src == dm) return 2'd1;
        if ((km == K_JAL || km == K_JALR) && src == dm) return 2'd2;
        if (src == dw) return 2'd3;
        return 2'd0;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        int         kd;
        int         ke;
        int         km;
        logic [4:0] de;
        logic [4:0] dm;
        logic [4:0] dw;
        logic       e_res;
        logic       stall;
        kd    = kind_of(ir_d);
        ke    = kind_of(ir_e);
        km    = kind_of(ir_m);
        de    = dest_of(ir_e);
        dm    = dest_of(ir_m);
        dw    = dest_of(ir_w);
        e_res = ke == K_CALR || ke == K_CALI || ke == K_LOAD;
        stall = 1'b0;
        if (kd == K_BR) begin  // Compare in decode reads rs and rt
            stall = (e_res && (hit(de, ir_d[25:21]) || hit(de, ir_d[20:16]))) ||
                    (km == K_LOAD && (hit(dm, ir_d[25:21]) || hit(dm, ir_d[20:16])));
        end
        if (kd == K_JR || kd == K_JALR) begin
            stall = (e_res && hit(de, ir_d[25:21])) || (km == K_LOAD && hit(dm, ir_d[25:21]));
        end
        if (ke == K_LOAD) begin
            if ((kd == K_CALI || kd == K_LOAD || kd == K_STORE) && hit(de, ir_d[25:21]))
                stall = 1'b1;
            if (kd == K_CALR && (hit(de, ir_d[25:21]) || hit(de, ir_d[20:16])))
                stall = 1'b1;
        end
        check("enable", enable, !stall);
        check("clear", clear, stall);
        check("fwd_rs_d", fwd_rs_d,
              fwd_model(kd == K_BR || kd == K_JR || kd == K_JALR, ir_d[25:21], km, dm, dw));
        check("fwd_rt_d", fwd_rt_d, fwd_model(kd == K_BR, ir_d[20:16], km, dm, dw));
        check("fwd_rs_e", fwd_rs_e,
              fwd_model(e_res || ke == K_STORE, ir_e[25:21], km, dm, dw));
        check("fwd_rt_e", fwd_rt_e,
              fwd_model(ke == K_CALR || ke == K_STORE, ir_e[20:16], km, dm, dw));
        check("fwd_rt_m", fwd_rt_m, (km == K_STORE && hit(dw, ir_m[20:16])) ? 2'd1 : 2'd0);
    endtask

    task automatic apply(input logic [31:0] wd, input logic [31:0] we,
                         input logic [31:0] wm, input logic [31:0] ww);
        @(posedge clk);
        #2;
        ir_d = wd;
        ir_e = we;
        ir_m = wm;
        ir_w = ww;
        @(negedge clk);  // Outputs settled long before here
        check_outputs();
    endtask

    task automatic report_test(input string name, input int base);
        $display("%-20s %s (%0d errors)", name, (errors == base) ? "ok" : "failed", errors - base);
    endtask

    //////////////////////////////////////////////////
    // Reset
    //////////////////////////////////////////////////
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        int base;
        seed   = 32'he8a1;
        clk    = 1'b0;
        ir_d   = '0;
        ir_e   = '0;
        ir_m   = '0;
        ir_w   = '0;
        errors = 0;
        checks = 0;
        wait (rst === 1'b0);  // Nop words stay on the stages until reset ends

        base = errors;
        repeat (4) begin
            apply('0, '0, '0, '0);
            check("enable", enable, 1);
            check("clear", clear, 0);
            check("fwd_all", {fwd_rs_d, fwd_rt_d, fwd_rs_e, fwd_rt_e, fwd_rt_m}, 0);
        end
        report_test("reset_nop", base);

        base = errors;
        repeat (200) apply(make_word(pick4(K_CALR, K_CALI, K_LOAD, K_STORE)),
                           make_word(K_LOAD), make_word(rand_kind()), make_word(rand_kind()));
        report_test("load_use_stall", base);

        base = errors;
        repeat (200) apply(make_word(pick4(K_BR, K_BR, K_JR, K_JALR)),
                           make_word(pick4(K_CALR, K_CALI, K_LOAD, K_NONE)),
                           make_word(pick4(K_LOAD, K_LOAD, K_CALI, K_STORE)),
                           make_word(rand_kind()));
        report_test("branch_jr_stall", base);

        base = errors;
        repeat (300) apply(make_word(pick4(K_BR, K_JR, K_JALR, K_CALR)),
                           make_word(pick4(K_CALR, K_CALI, K_LOAD, K_STORE)),
                           make_word(pick4(K_CALR, K_CALI, K_JAL, K_JALR)),
                           make_word(rand_kind()));
        report_test("forward_priority", base);

        base = errors;
        repeat (200) apply(make_word(rand_kind()), make_word(rand_kind()), make_word(K_STORE),
                           make_word(pick4(K_CALR, K_CALI, K_LOAD, K_JAL)));
        report_test("store_data_fwd", base);

        base = errors;
        repeat (2000) apply(make_word(rand_kind()), make_word(rand_kind()),
                            make_word(rand_kind()), make_word(rand_kind()));
        report_test("random_mix", base);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog allows one clock period per vector plus margin
    initial begin
        #((TOTAL_VECS + 100) * 20);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/hazard_pkg.sv
rtl/stage_info_if.sv
rtl/instr_classifier.sv
rtl/stall_detector.sv
rtl/forward_unit.sv
rtl/hazard_unit.sv
dv/tb_hazard_unit.sv

// ==== rtl/forward_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module forward_unit (
    stage_info_if.consumer       d,
    stage_info_if.consumer       e,
    stage_info_if.consumer       m,
    stage_info_if.consumer       w,
    output hazard_pkg::fwd_sel_t fwd_rs_d,
    output hazard_pkg::fwd_sel_t fwd_rt_d,
    output hazard_pkg::fwd_sel_t fwd_rs_e,
    output hazard_pkg::fwd_sel_t fwd_rt_e,
    output hazard_pkg::fwd_sel_t fwd_rt_m
);
    import hazard_pkg::*;

    reg_idx_t m_alu_dest;   // 0 unless memory holds an ALU result
    reg_idx_t m_link_dest;  // 0 unless memory holds jal or jalr
    logic     d_rs_use;
    logic     d_rt_use;
    logic     e_rs_use;
    logic     e_rt_use;

    // Nearest producer wins
    function automatic fwd_sel_t pick_src(
        input logic     reads,
        input reg_idx_t src,
        input reg_idx_t alu_dst,
        input reg_idx_t link_dst,
        input reg_idx_t wb_dst
    );
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (reads) begin
            if (alu_dst != '0 && src == alu_dst) begin
                sel = FWD_M_ALU;
            end else if (link_dst != '0 && src == link_dst) begin
                sel = FWD_M_LINK;
            end else if (wb_dst != '0 && src == wb_dst) begin
                sel = FWD_W;
            end
        end
        return sel;
    endfunction

    //////////////////////////////////////////////////
    // Producers and consumers
    //////////////////////////////////////////////////
    assign m_alu_dest  = (m.cal_r || m.cal_i) ? m.dest : '0;
    assign m_link_dest = (m.is_jal || m.is_jalr) ? m.dest : '0;

    assign d_rs_use = d.branch || d.jump_reg;
    assign d_rt_use = d.branch;
    assign e_rs_use = e.cal_r || e.cal_i || e.load || e.store;
    assign e_rt_use = e.cal_r || e.store;

    assign fwd_rs_d = pick_src(d_rs_use, d.rs, m_alu_dest, m_link_dest, w.dest);
    assign fwd_rt_d = pick_src(d_rt_use, d.rt, m_alu_dest, m_link_dest, w.dest);
    assign fwd_rs_e = pick_src(e_rs_use, e.rs, m_alu_dest, m_link_dest, w.dest);
    assign fwd_rt_e = pick_src(e_rt_use, e.rt, m_alu_dest, m_link_dest, w.dest);

    // Store data in memory can only come from write-back. The mux there has
    // two inputs, so the write-back leg takes encoding 1 (FWD_M_ALU's value)
    assign fwd_rt_m = (m.store && w.dest != '0 && w.dest == m.rt) ? FWD_M_ALU : FWD_NONE;

endmodule

`default_nettype wire

// ==== rtl/hazard_consts.svh ====
`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

//////////////////////////////////////////////////
// Primary opcodes
//////////////////////////////////////////////////
`define HZ_OP_SPECIAL  6'b000000  // R format, decoded by funct
`define HZ_OP_REGIMM   6'b000001  // bltz / bgez, decoded by rt
`define HZ_OP_J        6'b000010
`define HZ_OP_JAL      6'b000011
`define HZ_OP_BEQ      6'b000100
`define HZ_OP_BNE      6'b000101
`define HZ_OP_BLEZ     6'b000110
`define HZ_OP_BGTZ     6'b000111
`define HZ_OP_ADDI     6'b001000
`define HZ_OP_ADDIU    6'b001001
`define HZ_OP_SLTI     6'b001010
`define HZ_OP_SLTIU    6'b001011
`define HZ_OP_ANDI     6'b001100
`define HZ_OP_ORI      6'b001101
`define HZ_OP_XORI     6'b001110
`define HZ_OP_LUI      6'b001111
`define HZ_OP_LB       6'b100000
`define HZ_OP_LH       6'b100001
`define HZ_OP_LW       6'b100011
`define HZ_OP_LBU      6'b100100
`define HZ_OP_LHU      6'b100101
`define HZ_OP_SB       6'b101000
`define HZ_OP_SH       6'b101001
`define HZ_OP_SW       6'b101011

//////////////////////////////////////////////////
// Function codes under HZ_OP_SPECIAL
//////////////////////////////////////////////////
`define HZ_FN_SLL      6'b000000  // Also the all-zero nop
`define HZ_FN_SRL      6'b000010
`define HZ_FN_SRA      6'b000011
`define HZ_FN_SLLV     6'b000100
`define HZ_FN_SRLV     6'b000110
`define HZ_FN_SRAV     6'b000111
`define HZ_FN_JR       6'b001000
`define HZ_FN_JALR     6'b001001
`define HZ_FN_ADD      6'b100000
`define HZ_FN_ADDU     6'b100001
`define HZ_FN_SUB      6'b100010
`define HZ_FN_SUBU     6'b100011
`define HZ_FN_AND      6'b100100
`define HZ_FN_OR       6'b100101
`define HZ_FN_XOR      6'b100110
`define HZ_FN_NOR      6'b100111
`define HZ_FN_SLT      6'b101010
`define HZ_FN_SLTU     6'b101011

// Sub-opcodes in the rt field under HZ_OP_REGIMM
`define HZ_RT_BLTZ     5'b00000
`define HZ_RT_BGEZ     5'b00001

`define HZ_REG_RA      5'd31      // Link register written by jal
`define HZ_REG_W       5          // Register index width

`endif

// ==== rtl/hazard_pkg.sv ====
`default_nettype none

`include "hazard_consts.svh"

package hazard_pkg;

    typedef logic [`HZ_REG_W-1:0] reg_idx_t;

    // R format view of an instruction word
    typedef struct packed {
        logic [5:0] op;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // I format view, rt doubles as regimm sub-opcode
    typedef struct packed {
        logic [5:0]  op;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    // Operand source selection
    typedef enum logic [1:0] {
        FWD_NONE   = 2'd0,  // Register file value
        FWD_M_ALU  = 2'd1,  // Memory stage ALU result
        FWD_M_LINK = 2'd2,  // Memory stage link address
        FWD_W      = 2'd3   // Write-back value
    } fwd_sel_t;

endpackage

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  logic [31:0] ir_d,
    input  logic [31:0] ir_e,
    input  logic [31:0] ir_m,
    input  logic [31:0] ir_w,
    output logic [1:0]  fwd_rs_d,
    output logic [1:0]  fwd_rt_d,
    output logic [1:0]  fwd_rs_e,
    output logic [1:0]  fwd_rt_e,
    output logic [1:0]  fwd_rt_m,
    output logic        enable,
    output logic        clear
);

    stage_info_if info_d ();
    stage_info_if info_e ();
    stage_info_if info_m ();
    stage_info_if info_w ();

    //////////////////////////////////////////////////
    // One classifier per pipeline stage
    //////////////////////////////////////////////////
    instr_classifier i_class_d (.ir(ir_d), .info(info_d));
    instr_classifier i_class_e (.ir(ir_e), .info(info_e));
    instr_classifier i_class_m (.ir(ir_m), .info(info_m));
    instr_classifier i_class_w (.ir(ir_w), .info(info_w));

    stall_detector i_stall (
        .d      (info_d),
        .e      (info_e),
        .m      (info_m),
        .enable (enable),
        .clear  (clear)
    );

    forward_unit i_fwd (
        .d        (info_d),
        .e        (info_e),
        .m        (info_m),
        .w        (info_w),
        .fwd_rs_d (fwd_rs_d),
        .fwd_rt_d (fwd_rt_d),
        .fwd_rs_e (fwd_rs_e),
        .fwd_rt_e (fwd_rt_e),
        .fwd_rt_m (fwd_rt_m)  // Store data in memory
    );

endmodule

`default_nettype wire

// ==== rtl/instr_classifier.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hazard_consts.svh"

module instr_classifier (
    input hazard_pkg::instr_t ir,
    stage_info_if.producer    info
);
    import hazard_pkg::*;

    logic     cal_r;
    logic     cal_i;
    logic     load;
    logic     store;
    logic     branch;
    logic     jump_reg;
    logic     is_jal;
    logic     is_jalr;
    reg_idx_t dest;

    //////////////////////////////////////////////////
    // Class decode
    //////////////////////////////////////////////////
    always_comb begin
        cal_r    = 1'b0;
        cal_i    = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
        branch   = 1'b0;
        jump_reg = 1'b0;
        is_jal   = 1'b0;
        is_jalr  = 1'b0;
        case (ir.r.op)
            `HZ_OP_SPECIAL: begin
                case (ir.r.funct)
                    `HZ_FN_SLL, `HZ_FN_SRL, `HZ_FN_SRA,
                    `HZ_FN_SLLV, `HZ_FN_SRLV, `HZ_FN_SRAV,
                    `HZ_FN_ADD, `HZ_FN_ADDU, `HZ_FN_SUB, `HZ_FN_SUBU,
                    `HZ_FN_AND, `HZ_FN_OR, `HZ_FN_XOR, `HZ_FN_NOR,
                    `HZ_FN_SLT, `HZ_FN_SLTU: cal_r = 1'b1;
                    `HZ_FN_JR:               jump_reg = 1'b1;
                    `HZ_FN_JALR: begin
                        jump_reg = 1'b1;  // Reads rs like jr
                        is_jalr  = 1'b1;
                    end
                    default: ;
                endcase
            end
            `HZ_OP_REGIMM: begin
                if (ir.i.rt == `HZ_RT_BLTZ || ir.i.rt == `HZ_RT_BGEZ) begin
                    branch = 1'b1;
                end
            end
            `HZ_OP_BEQ, `HZ_OP_BNE,
            `HZ_OP_BLEZ, `HZ_OP_BGTZ:  branch = 1'b1;
            `HZ_OP_ADDI, `HZ_OP_ADDIU, `HZ_OP_SLTI, `HZ_OP_SLTIU,
            `HZ_OP_ANDI, `HZ_OP_ORI, `HZ_OP_XORI,
            `HZ_OP_LUI:                cal_i = 1'b1;
            `HZ_OP_LB, `HZ_OP_LBU, `HZ_OP_LH,
            `HZ_OP_LHU, `HZ_OP_LW:     load = 1'b1;
            `HZ_OP_SB, `HZ_OP_SH,
            `HZ_OP_SW:                 store = 1'b1;
            `HZ_OP_JAL:                is_jal = 1'b1;
            `HZ_OP_J:                  ;  // Reads and writes no register
            default:                   ;
        endcase
    end

    // Destination register, one rule for every stage
    always_comb begin
        if (cal_r || is_jalr) begin
            dest = ir.r.rd;
        end else if (cal_i || load) begin
            dest = ir.i.rt;
        end else if (is_jal) begin
            dest = `HZ_REG_RA;
        end else begin
            dest = '0;
        end
    end

    assign info.cal_r    = cal_r;
    assign info.cal_i    = cal_i;
    assign info.load     = load;
    assign info.store    = store;
    assign info.branch   = branch;
    assign info.jump_reg = jump_reg;
    assign info.is_jal   = is_jal;
    assign info.is_jalr  = is_jalr;
    assign info.rs       = ir.r.rs;
    assign info.rt       = ir.r.rt;
    assign info.dest     = dest;

endmodule

`default_nettype wire

// ==== rtl/stage_info_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface stage_info_if;
    import hazard_pkg::*;

    logic     cal_r;     // Register-register ALU op
    logic     cal_i;     // Immediate ALU op
    logic     load;
    logic     store;
    logic     branch;    // Conditional branch, reads rs and maybe rt
    logic     jump_reg;  // jr or jalr
    logic     is_jal;
    logic     is_jalr;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;      // 0 means no register write

    modport producer (
        output cal_r, cal_i, load, store, branch, jump_reg,
        output is_jal, is_jalr, rs, rt, dest
    );

    modport consumer (
        input cal_r, cal_i, load, store, branch, jump_reg,
        input is_jal, is_jalr, rs, rt, dest
    );

endinterface

`default_nettype wire

// ==== rtl/stall_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

module stall_detector (
    stage_info_if.consumer d,
    stage_info_if.consumer e,
    stage_info_if.consumer m,
    output logic           enable,
    output logic           clear
);

    logic e_hit_rs;     // Execute result feeds decode rs
    logic e_hit_rt;
    logic m_hit_rs;     // Memory result feeds decode rs
    logic m_hit_rt;
    logic e_result;     // Execute holds a register producer
    logic stall_ctl_e;
    logic stall_load_e;
    logic stall_load_m;
    logic stall;

    assign e_hit_rs = (e.dest != '0) && (e.dest == d.rs);
    assign e_hit_rt = (e.dest != '0) && (e.dest == d.rt);
    assign m_hit_rs = (m.dest != '0) && (m.dest == d.rs);
    assign m_hit_rt = (m.dest != '0) && (m.dest == d.rt);

    assign e_result = e.cal_r || e.cal_i || e.load;

    //////////////////////////////////////////////////
    // Stall terms
    //////////////////////////////////////////////////

    // Branch and jr compare in decode, so no execute result is ready in time
    assign stall_ctl_e = e_result &&
                         ((d.branch && (e_hit_rs || e_hit_rt)) ||
                          (d.jump_reg && e_hit_rs));

    // Load data arrives after execute
    assign stall_load_e = e.load &&
                          (((d.cal_i || d.load || d.store) && e_hit_rs) ||
                           (d.cal_r && (e_hit_rs || e_hit_rt)));

    // Load still in memory, too late for a decode compare
    assign stall_load_m = m.load &&
                          ((d.branch && (m_hit_rs || m_hit_rt)) ||
                           (d.jump_reg && m_hit_rs));

    assign stall  = stall_ctl_e || stall_load_e || stall_load_m;
    assign enable = !stall;  // Holds PC and decode register
    assign clear  = stall;   // Bubble into execute

endmodule

`default_nettype wire
